// File: logic/isaPkg.sv
// instruction set constants, imported by decode, ALU, register file and fetch
package isaPkg;

	localparam int dataWidth  = 16;  // data and address width
	localparam int regCount   = 16;
	localparam int regIdWidth = 4;
	localparam int opWidth    = 4;
	localparam int condWidth  = 3;
	localparam int flagCount  = 3;

	// opcodes, top nibble of the instruction
	localparam logic [opWidth-1:0] opAdd = 4'h0;  // saturating
	localparam logic [opWidth-1:0] opSub = 4'h1;  // saturating
	localparam logic [opWidth-1:0] opXor = 4'h2;
	localparam logic [opWidth-1:0] opSll = 4'h4;
	localparam logic [opWidth-1:0] opLw  = 4'h8;
	localparam logic [opWidth-1:0] opSw  = 4'h9;
	localparam logic [opWidth-1:0] opLlb = 4'ha;
	localparam logic [opWidth-1:0] opLhb = 4'hb;
	localparam logic [opWidth-1:0] opBr  = 4'hc;
	localparam logic [opWidth-1:0] opHlt = 4'hf;

	// branch conditions in bits 11:9
	localparam logic [condWidth-1:0] condNe     = 3'd0;
	localparam logic [condWidth-1:0] condEq     = 3'd1;
	localparam logic [condWidth-1:0] condGt     = 3'd2;
	localparam logic [condWidth-1:0] condLt     = 3'd3;
	localparam logic [condWidth-1:0] condGe     = 3'd4;
	localparam logic [condWidth-1:0] condLe     = 3'd5;
	localparam logic [condWidth-1:0] condOv     = 3'd6;
	localparam logic [condWidth-1:0] condAlways = 3'd7;

	// field positions
	localparam int opMsb     = 15;
	localparam int opLsb     = 12;
	localparam int rdMsb     = 11;  // rd, also rt of lw/sw
	localparam int rdLsb     = 8;
	localparam int rsMsb     = 7;
	localparam int rsLsb     = 4;
	localparam int rtMsb     = 3;
	localparam int rtLsb     = 0;
	localparam int condMsb   = 11;
	localparam int condLsb   = 9;
	localparam int brOffMsb  = 8;   // nine-bit branch offset
	localparam int immMsb    = 7;   // llb/lhb byte
	localparam int offsetMsb = 3;   // lw/sw offset, sll amount

	// flag bits, ZVN order
	localparam int flagZ = 2;
	localparam int flagV = 1;
	localparam int flagN = 0;

	localparam int romWords  = 256;
	localparam int dataWords = 256;

endpackage

// File: logic/pipePkg.sv
// fetch pipeline sizes and the fetch entry layout, imported by fetch, queue, core and top
package pipePkg;

	localparam int queueDepth  = 4;  // entries in the instruction queue
	localparam int creditWidth = 3;  // holds 0..queueDepth

	// one fetched instruction with its address
	typedef struct packed {
		logic [15:0] pc;
		logic [15:0] instruction;
	} fetchEntry;

endpackage

// File: logic/regFile.sv
// register file for the core: r0 reads zero, two combinational reads with write bypass
module regFile import isaPkg::*; (
	input  logic                  clk,
	input  logic                  reset,
	input  logic [regIdWidth-1:0] readRegA,
	input  logic [regIdWidth-1:0] readRegB,
	input  logic                  writeEnable,
	input  logic [regIdWidth-1:0] writeReg,
	input  logic [dataWidth-1:0]  writeData,
	output logic [dataWidth-1:0]  readDataA,
	output logic [dataWidth-1:0]  readDataB
);

	logic [dataWidth-1:0] regs [regCount];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < regCount; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEnable && (writeReg != '0)) begin
			regs[writeReg] <= writeData;
		end
	end

	// r0 first, then same-cycle write, then array
	assign readDataA = (readRegA == '0) ? '0 :
		(writeEnable && (writeReg == readRegA)) ? writeData : regs[readRegA];
	assign readDataB = (readRegB == '0) ? '0 :
		(writeEnable && (writeReg == readRegB)) ? writeData : regs[readRegB];

endmodule

// File: logic/aluUnit.sv
// execute ALU: saturating add/sub, xor, shift, byte loads, lw/sw address and ZVN flags
module aluUnit import isaPkg::*; (
	input  logic [opWidth-1:0]   opcode,
	input  logic [dataWidth-1:0] operandA,
	input  logic [dataWidth-1:0] operandB,   // rt value or raw immediate
	output logic [dataWidth-1:0] result,
	output logic [flagCount-1:0] flags,
	output logic [flagCount-1:0] flagWrite   // which flags this op updates
);

	logic                 isSub;
	logic [dataWidth-1:0] addIn;
	logic [dataWidth-1:0] rawSum;
	logic                 overflow;
	logic [dataWidth-1:0] satValue;
	logic [dataWidth-1:0] memOffset;

	// sub as a + ~b + 1
	assign isSub    = (opcode == opSub);
	assign addIn    = isSub ? ~operandB : operandB;
	assign rawSum   = operandA + addIn + dataWidth'(isSub);
	assign overflow = (operandA[dataWidth-1] == addIn[dataWidth-1]) &&
		(rawSum[dataWidth-1] != operandA[dataWidth-1]);
	assign satValue = {operandA[dataWidth-1], {(dataWidth-1){~operandA[dataWidth-1]}}};

	// sign-extended word offset, times two
	assign memOffset = {{(dataWidth-offsetMsb-2){operandB[offsetMsb]}},
		operandB[offsetMsb:0], 1'b0};

	always_comb begin
		result    = operandA;
		flagWrite = '0;
		case (opcode)
			opAdd, opSub: begin
				result    = overflow ? satValue : rawSum;  // clamp to signed limit
				flagWrite = '1;
			end
			opXor: begin
				result           = operandA ^ operandB;
				flagWrite[flagZ] = 1'b1;
			end
			opSll: begin
				result           = operandA << operandB[offsetMsb:0];
				flagWrite[flagZ] = 1'b1;
			end
			opLlb: result = {operandA[dataWidth-1:immMsb+1], operandB[immMsb:0]};
			opLhb: result = {operandB[immMsb:0], operandA[immMsb:0]};
			opLw, opSw: result = operandA + memOffset;  // address
			default: result = operandA;  // br, hlt, unused
		endcase
	end

	always_comb begin
		flags        = '0;
		flags[flagZ] = (result == '0);
		flags[flagV] = overflow;          // only kept for add/sub
		flags[flagN] = result[dataWidth-1];
	end

endmodule

// File: logic/fetchUnit.sv
// instruction fetch: reads the program ROM and pushes entries to the queue against credits
module fetchUnit import isaPkg::*, pipePkg::*; (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 creditReturn,  // one per queue pop
	input  logic                 redirect,      // taken branch from core
	input  logic [dataWidth-1:0] redirectPc,
	output logic                 pushValid,
	output fetchEntry            pushEntry,
	output logic [dataWidth-1:0] pc             // next address to fetch
);

	logic [dataWidth-1:0]   rom [romWords];
	logic [dataWidth-1:0]   fetchedWord;
	logic [creditWidth-1:0] credits;
	logic                   stopped;  // hlt already pushed
	logic                   issue;

	initial begin
		$readmemh("program.hex", rom);
	end

	// halfword addressed, drop bit 0
	assign fetchedWord = rom[pc[$clog2(romWords):1]];

	// a credit means a free queue slot
	assign issue = (credits != '0) && !stopped;

	always_ff @(posedge clk) begin
		if (reset) begin
			pc        <= '0;
			credits   <= creditWidth'(queueDepth);
			stopped   <= 1'b0;
			pushValid <= 1'b0;
		end else if (redirect) begin
			// queue is flushed on the same edge, so all credits come back
			pc        <= redirectPc;
			credits   <= creditWidth'(queueDepth);
			stopped   <= 1'b0;
			pushValid <= 1'b0;
		end else begin
			pushValid <= issue;
			credits   <= credits + creditWidth'(creditReturn) - creditWidth'(issue);
			if (issue) begin
				if (fetchedWord[opMsb:opLsb] == opHlt) begin
					stopped <= 1'b1;  // pc parks on the hlt
				end else begin
					pc <= pc + dataWidth'(2);
				end
			end
		end
	end

	// entry payload
	always_ff @(posedge clk) begin
		if (issue) begin
			pushEntry.pc          <= pc;
			pushEntry.instruction <= fetchedWord;
		end
	end

endmodule

// File: logic/instrQueue.sv
// instruction queue between fetch and core: circular FIFO with flush and credit return
module instrQueue import pipePkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  logic      pushValid,
	input  fetchEntry pushEntry,
	input  logic      pop,
	input  logic      flush,        // taken branch, drop everything
	output logic      headValid,
	output fetchEntry headEntry,
	output logic      creditReturn
);

	fetchEntry                      slots [queueDepth];
	logic [$clog2(queueDepth)-1:0] readPtr;
	logic [$clog2(queueDepth)-1:0] writePtr;
	logic [creditWidth-1:0]        count;
	logic                          doPush;
	logic                          doPop;

	// pushes arriving with a flush are wrong path
	assign doPush = pushValid && !flush;
	assign doPop  = pop && headValid;

	assign headValid    = (count != '0);
	assign headEntry    = slots[readPtr];  // combinational head
	assign creditReturn = doPop;           // slot freed this cycle

	always_ff @(posedge clk) begin
		if (reset || flush) begin
			readPtr  <= '0;
			writePtr <= '0;
			count    <= '0;
		end else begin
			if (doPush) begin
				writePtr <= writePtr + 1'b1;  // wraps at depth
			end
			if (doPop) begin
				readPtr <= readPtr + 1'b1;
			end
			count <= count + creditWidth'(doPush) - creditWidth'(doPop);
		end
	end

	// storage, no overflow check needed with credits
	always_ff @(posedge clk) begin
		if (doPush) begin
			slots[writePtr] <= pushEntry;
		end
	end

endmodule

// File: logic/execCore.sv
// execute core: decode, writeback forwarding, flags, branch resolve, data memory, writeback
module execCore import isaPkg::*, pipePkg::*; (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  run,          // low holds the core
	input  logic                  headValid,
	input  fetchEntry             headEntry,
	output logic                  pop,
	output logic                  redirect,     // taken branch this cycle
	output logic [dataWidth-1:0]  redirectPc,
	output logic                  hlt,
	output logic                  retireValid,
	output logic [regIdWidth-1:0] retireReg,
	output logic [dataWidth-1:0]  retireData
);

	logic [dataWidth-1:0]         instr;
	logic [opWidth-1:0]           opcode;
	logic [condWidth-1:0]         cond;
	logic [regIdWidth-1:0]        destReg;
	logic [regIdWidth-1:0]        readRegA;
	logic [regIdWidth-1:0]        readRegB;
	logic [dataWidth-1:0]         readDataA;
	logic [dataWidth-1:0]         readDataB;
	logic [dataWidth-1:0]         srcA;
	logic [dataWidth-1:0]         srcB;
	logic [dataWidth-1:0]         operandB;
	logic [dataWidth-1:0]         aluResult;
	logic [flagCount-1:0]         aluFlags;
	logic [flagCount-1:0]         aluFlagWrite;
	logic [flagCount-1:0]         flagReg;
	logic                         exec;
	logic                         condMet;
	logic                         writesReg;
	logic                         usesRt;
	logic [dataWidth-1:0]         branchOffset;
	logic [dataWidth-1:0]         dataMem [dataWords];
	logic [$clog2(dataWords)-1:0] memIndex;
	logic [dataWidth-1:0]         loadData;
	logic [dataWidth-1:0]         wbData;
	logic                         wbIsLoad;

	assign instr  = headEntry.instruction;
	assign opcode = instr[opMsb:opLsb];
	assign cond   = instr[condMsb:condLsb];

	assign pop  = headValid && run && !hlt;
	assign exec = pop;  // head executes as it is popped

	// port A gets rd for byte loads, port B gets rt data for sw
	assign readRegA = (opcode inside {opLlb, opLhb}) ? instr[rdMsb:rdLsb] : instr[rsMsb:rsLsb];
	assign readRegB = (opcode == opSw) ? instr[rdMsb:rdLsb] : instr[rtMsb:rtLsb];
	assign destReg  = instr[rdMsb:rdLsb];

	assign usesRt    = opcode inside {opAdd, opSub, opXor};
	assign writesReg = opcode inside {opAdd, opSub, opXor, opSll, opLw, opLlb, opLhb};

	regFile regs (
		.clk         (clk),
		.reset       (reset),
		.readRegA    (readRegA),
		.readRegB    (readRegB),
		.writeEnable (retireValid),
		.writeReg    (retireReg),
		.writeData   (retireData),
		.readDataA   (readDataA),
		.readDataB   (readDataB)
	);

	// forward from writeback, covers lw data arriving this cycle
	assign srcA = (retireValid && (retireReg == readRegA)) ? retireData : readDataA;
	assign srcB = (retireValid && (retireReg == readRegB)) ? retireData : readDataB;
	assign operandB = usesRt ? srcB : dataWidth'(instr[immMsb:0]);  // raw low byte

	aluUnit alu (
		.opcode    (opcode),
		.operandA  (srcA),
		.operandB  (operandB),
		.result    (aluResult),
		.flags     (aluFlags),
		.flagWrite (aluFlagWrite)
	);

	always_comb begin
		case (cond)
			condNe:     condMet = !flagReg[flagZ];
			condEq:     condMet = flagReg[flagZ];
			condGt:     condMet = !flagReg[flagZ] && !flagReg[flagN];
			condLt:     condMet = flagReg[flagN];
			condGe:     condMet = flagReg[flagZ] || !flagReg[flagN];
			condLe:     condMet = flagReg[flagZ] || flagReg[flagN];
			condOv:     condMet = flagReg[flagV];
			condAlways: condMet = 1'b1;
			default:    condMet = 1'b0;
		endcase
	end

	// pc + 2 + 2 * sext(offset9)
	assign branchOffset = {{(dataWidth-brOffMsb-2){instr[brOffMsb]}}, instr[brOffMsb:0], 1'b0};
	assign redirectPc   = headEntry.pc + dataWidth'(2) + branchOffset;
	assign redirect     = exec && (opcode == opBr) && condMet;

	// flags and halt
	always_ff @(posedge clk) begin
		if (reset) begin
			flagReg <= '0;
			hlt     <= 1'b0;
		end else if (exec) begin
			flagReg <= (flagReg & ~aluFlagWrite) | (aluFlags & aluFlagWrite);  // masked update
			if (opcode == opHlt) begin
				hlt <= 1'b1;  // sticky until reset
			end
		end
	end

	// data memory, word addressed, starts cleared
	assign memIndex = aluResult[$clog2(dataWords):1];

	initial begin
		for (int i = 0; i < dataWords; i++) begin
			dataMem[i] = '0;
		end
	end

	always_ff @(posedge clk) begin
		if (exec && (opcode == opSw)) begin
			dataMem[memIndex] <= srcB;
		end
		if (exec && (opcode == opLw)) begin
			loadData <= dataMem[memIndex];  // lands in writeback cycle
		end
	end

	// writeback register
	always_ff @(posedge clk) begin
		if (reset) begin
			retireValid <= 1'b0;
			wbIsLoad    <= 1'b0;
		end else begin
			retireValid <= exec && writesReg && (destReg != '0);  // r0 writes dropped
			wbIsLoad    <= exec && (opcode == opLw);
		end
	end

	always_ff @(posedge clk) begin
		if (exec) begin
			retireReg <= destReg;
			wbData    <= aluResult;
		end
	end

	assign retireData = wbIsLoad ? loadData : wbData;

endmodule

// File: logic/cpuTop.sv
// processor top: fetch unit feeding the instruction queue feeding the execute core
module cpuTop import pipePkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  logic        run,          // low pauses the core
	output logic        hlt,
	output logic [15:0] pc,           // fetch pc
	output logic        retireValid,
	output logic [3:0]  retireReg,
	output logic [15:0] retireData
);

	logic        pushValid;
	fetchEntry   pushEntry;
	logic        creditReturn;
	logic        headValid;
	fetchEntry   headEntry;
	logic        pop;
	logic        redirect;
	logic [15:0] redirectPc;

	fetchUnit fetch (
		.clk          (clk),
		.reset        (reset),
		.creditReturn (creditReturn),
		.redirect     (redirect),
		.redirectPc   (redirectPc),
		.pushValid    (pushValid),
		.pushEntry    (pushEntry),
		.pc           (pc)
	);

	instrQueue queue (
		.clk          (clk),
		.reset        (reset),
		.pushValid    (pushValid),
		.pushEntry    (pushEntry),
		.pop          (pop),
		.flush        (redirect),     // taken branch empties it
		.headValid    (headValid),
		.headEntry    (headEntry),
		.creditReturn (creditReturn)
	);

	execCore core (
		.clk         (clk),
		.reset       (reset),
		.run         (run),
		.headValid   (headValid),
		.headEntry   (headEntry),
		.pop         (pop),
		.redirect    (redirect),
		.redirectPc  (redirectPc),
		.hlt         (hlt),
		.retireValid (retireValid),
		.retireReg   (retireReg),
		.retireData  (retireData)
	);

endmodule

// File: dv/cpuTb.sv
// testbench for cpuTop: random run gaps, sequential ISA reference model, assertion checks
module cpuTb import isaPkg::*, pipePkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int maxSteps    = 1000;   // model step limit
	localparam int haltTimeout = 20000;  // cycles to wait for hlt

	logic        clk;
	logic        reset;
	logic        run;
	logic        hlt;
	logic [15:0] pc;
	logic        retireValid;
	logic [3:0]  retireReg;
	logic [15:0] retireData;

	logic [15:0] progMem [romWords];
	logic [15:0] modelRegs [regCount];
	logic [15:0] modelMem [dataWords];
	logic [3:0]  expReg [maxSteps];
	logic [15:0] expData [maxSteps];
	int          retireIdx [maxSteps];  // trace index of each retiring instruction
	logic [15:0] tracePc [maxSteps];    // every executed pc, in order
	int          expCount;
	int          traceLen;
	int          retireCount;
	int          burstLeft;

	cpuTop DUT (
		.clk         (clk),
		.reset       (reset),
		.run         (run),
		.hlt         (hlt),
		.pc          (pc),
		.retireValid (retireValid),
		.retireReg   (retireReg),
		.retireData  (retireData)
	);

	always #5 clk = ~clk;

	task automatic stopRun();
		$display("Test FAILED");
		$fatal(1);
	endtask

	// signed 17-bit result clamped to the 16-bit range
	function automatic logic [15:0] saturate(input logic [15:0] a, input logic [15:0] b,
		input bit subtract, output bit clamped);
		logic signed [16:0] wide;
		wide = subtract ? ($signed({a[15], a}) - $signed({b[15], b})) :
			($signed({a[15], a}) + $signed({b[15], b}));
		clamped = 1'b0;
		if (wide > 17'sd32767) begin
			clamped = 1'b1;
			return 16'h7fff;
		end
		if (wide < -17'sd32768) begin
			clamped = 1'b1;
			return 16'h8000;
		end
		return wide[15:0];
	endfunction

	function automatic bit condHolds(input logic [2:0] cond, input bit z, input bit v, input bit n);
		case (cond)
			3'd0: return !z;
			3'd1: return z;
			3'd2: return !z && !n;
			3'd3: return n;
			3'd4: return z || !n;
			3'd5: return z || n;
			3'd6: return v;
			default: return 1'b1;
		endcase
	endfunction

	// runs the program in order and records the expected register writes
	task automatic buildModel();
		logic [15:0] mpc;
		logic [15:0] nextPc;
		logic [15:0] ins;
		logic [15:0] a;
		logic [15:0] res;
		logic [15:0] addr;
		logic [3:0]  rd;
		bit          z;
		bit          v;
		bit          n;
		bit          clamped;
		bit          writes;
		bit          done;
		mpc      = '0;
		z        = 0;
		v        = 0;
		n        = 0;
		done     = 0;
		expCount = 0;
		traceLen = 0;
		for (int i = 0; i < regCount; i++) modelRegs[i] = '0;
		for (int i = 0; i < dataWords; i++) modelMem[i] = '0;
		while (!done) begin
			if (traceLen >= maxSteps) begin
				$display("reference model ran %0d steps without reaching HLT", maxSteps);
				stopRun();
			end
			ins    = progMem[mpc[8:1]];
			rd     = ins[11:8];
			a      = modelRegs[ins[7:4]];
			addr   = a + {{11{ins[3]}}, ins[3:0], 1'b0};  // lw/sw word offset
			nextPc = mpc + 16'd2;
			writes = 0;
			res    = '0;
			tracePc[traceLen] = mpc;
			case (ins[15:12])
				opAdd, opSub: begin
					res    = saturate(a, modelRegs[ins[3:0]], ins[15:12] == opSub, clamped);
					z      = (res == 0);
					n      = res[15];
					v      = clamped;
					writes = 1;
				end
				opXor: begin
					res    = a ^ modelRegs[ins[3:0]];
					z      = (res == 0);  // only Z for logic ops
					writes = 1;
				end
				opSll: begin
					res    = a << ins[3:0];
					z      = (res == 0);
					writes = 1;
				end
				opLw: begin
					res    = modelMem[addr[8:1]];
					writes = 1;
				end
				opSw: modelMem[addr[8:1]] = modelRegs[rd];
				opLlb: begin
					res    = {modelRegs[rd][15:8], ins[7:0]};
					writes = 1;
				end
				opLhb: begin
					res    = {ins[7:0], modelRegs[rd][7:0]};
					writes = 1;
				end
				opBr: if (condHolds(ins[11:9], z, v, n)) nextPc = mpc + 16'd2 +
					{{6{ins[8]}}, ins[8:0], 1'b0};
				opHlt: done = 1;
				default: begin
					$display("program holds unknown opcode %h at pc %h", ins[15:12], mpc);
					stopRun();
				end
			endcase
			if (writes && rd != 0) begin  // r0 never retires
				modelRegs[rd]       = res;
				expReg[expCount]    = rd;
				expData[expCount]   = res;
				retireIdx[expCount] = traceLen;
				expCount++;
			end
			traceLen++;
			mpc = nextPc;
		end
	endtask

	// fetch pc lies at most one queue plus one push past some instruction that may be the last executed
	function automatic bit pcInWindow(input logic [15:0] fetchPc, input int count);
		int          lo;
		int          hi;
		logic [15:0] gap;
		lo = (count == 0) ? 0 : retireIdx[count - 1];
		hi = (count < expCount) ? retireIdx[count] : traceLen - 1;
		for (int i = lo; i <= hi; i++) begin
			gap = fetchPc - tracePc[i];
			if (gap <= 16'(2 * queueDepth + 2)) return 1;
		end
		return 0;
	endfunction

	always @(posedge clk) begin
		if (reset) retireCount <= 0;
		else if (retireValid) retireCount <= retireCount + 1;
	end

	// run stimulus, with 10-cycle stalls now and then
	task automatic driveRun();
		int r;
		forever begin
			@(posedge clk);
			r = $urandom % 16;
			if (reset) begin
				run       <= 1'b1;
				burstLeft = 0;
			end else if (burstLeft > 0) begin
				run       <= 1'b0;
				burstLeft = burstLeft - 1;
			end else if (r == 0) begin
				run       <= 1'b0;
				burstLeft = 9;
			end else begin
				run <= (r > 3);
			end
		end
	endtask

	assert property (@(posedge clk) disable iff (reset) retireValid |-> retireCount < expCount)
		else begin
			$display("%0t: a register write retired after the expected list ran out", $time);
			stopRun();
		end
	assert property (@(posedge clk) disable iff (reset)
		retireValid && retireCount < expCount |-> retireReg == expReg[retireCount])
		else begin
			$display("[ERROR] %0t retireReg expected %0d got %0d", $time,
				expReg[$sampled(retireCount)], $sampled(retireReg));
			stopRun();
		end
	assert property (@(posedge clk) disable iff (reset)
		retireValid && retireCount < expCount |-> retireData == expData[retireCount])
		else begin
			$display("[ERROR] %0t retireData expected %h got %h", $time,
				expData[$sampled(retireCount)], $sampled(retireData));
			stopRun();
		end
	assert property (@(posedge clk) disable iff (reset) !run |=> !retireValid)
		else begin
			$display("[ERROR] %0t retireValid expected 0 got 1", $time);
			stopRun();
		end
	assert property (@(posedge clk) disable iff (reset) pcInWindow(pc, retireCount))
		else begin
			$display("[ERROR] %0t pc expected within %0d bytes of an executed pc got %h",
				$time, 2 * queueDepth + 2, $sampled(pc));
			stopRun();
		end
	assert property (@(posedge clk) disable iff (reset) $rose(hlt) |-> retireCount == expCount)
		else begin
			$display("[ERROR] %0t retireCount expected %0d got %0d", $time, expCount,
				$sampled(retireCount));
			stopRun();
		end
	assert property (@(posedge clk) disable iff (reset) hlt |=> hlt)
		else begin
			$display("[ERROR] %0t hlt expected 1 got 0", $time);
			stopRun();
		end
	assert property (@(posedge clk) disable iff (reset) hlt |-> !retireValid)
		else begin
			$display("[ERROR] %0t retireValid expected 0 got 1", $time);
			stopRun();
		end

	task automatic waitForHalt(output bit halted);
		halted = 0;
		for (int i = 0; i < haltTimeout; i++) begin
			@(posedge clk);
			if (hlt) begin
				halted = 1;
				return;
			end
		end
	endtask

	initial begin
		bit halted;
		void'($urandom(63));
		clk   = 1'b0;
		reset = 1'b1;
		run   = 1'b0;
		$readmemh("program.hex", progMem);
		buildModel();
		fork
			driveRun();  // random stream follows from the seed above
		join_none
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		waitForHalt(halted);
		if (halted) begin
			repeat (20) @(posedge clk);  // hlt must hold with no retires
			$display("Test OK");
			$finish;
		end else begin
			$display("waiting for hlt expired after %0d cycles", haltTimeout);
			stopRun();
		end
	end

endmodule

// File: build.f
logic/isaPkg.sv
logic/pipePkg.sv
logic/regFile.sv
logic/aluUnit.sv
logic/fetchUnit.sv
logic/instrQueue.sv
logic/execCore.sv
logic/cpuTop.sv
dv/cpuTb.sv

// File: program.hex
// test program for the core, one 16-bit instruction word per entry, in address order
// nibbles are op rd rs rt, or op rd imm8, or op cond+offset9; EE writes mark wrong path
A105 B17F A200 B240 0312 CC01 A4EE 1521
C601 A4EE C401 A633 C801 2766 C201 A4EE
C001 CA01 A4EE 4814 C001 A4EE C201 CC01
CA01 A4EE 0966 C401 A4EE C801 A4EE C601
CA01 9302 8A02 0BAA 1C51 9C0F 8D0F AF01
AE03 1EEF C1FE CE01 A4EE 0011 244F F000
A4EE
